/* logic/frame_pkg.sv */
// input-side types shared by the frame writer, the descriptor FIFO and the frame reader
`default_nettype none

package frame_pkg;

    // MAC word and frame RAM word width
    localparam int frame_data_w = 32;

    typedef logic [10:0] frame_addr_t;
    typedef logic [11:0] frame_len_t;
    typedef logic [15:0] filter_index_t;

    // class code from the MAC classifier
    typedef enum logic [1:0] {
        other        = 2'b00,
        udp_match    = 2'b01,
        ip_match     = 2'b10,
        checksum_err = 2'b11
    } pkt_class_e;

    // one queued frame with its start as a frame RAM word address
    typedef struct packed {
        frame_addr_t   start_addr;
        frame_len_t    len;
        pkt_class_e    pkt_class;
        filter_index_t filter_index;
    } frame_desc_t;

    // MAC receive beat; frmlen, pkt_type and filter index only count with eop
    typedef struct packed {
        logic                    sop;
        logic                    eop;
        logic                    valid;
        logic [frame_data_w-1:0] data;
        frame_len_t              frmlen;
        pkt_class_e              pkt_type;
        filter_index_t           udp_filter_index;
    } mac_rx_t;

endpackage

`default_nettype wire

/* logic/udp_out_pkg.sv */
// output-side types for the UDP payload RAM port, its descriptor and the reader beats
`default_nettype none

package udp_out_pkg;

    // ethernet, ipv4 and udp headers ahead of the payload
    localparam int udp_hdr_bytes = 42;

    typedef struct packed {
        logic        wren;
        logic [9:0]  waddr;
        logic [31:0] wdata;
    } udp_wr_t;

    // one pulse per copied frame
    typedef struct packed {
        logic        valid;
        logic [15:0] dst_port;
        logic [11:0] pay_len;
        logic [9:0]  start_addr;
    } udp_desc_t;

    // lines up with frame RAM read data
    typedef struct packed {
        logic valid;
        logic first;
        logic last;
    } rd_beat_t;

endpackage

`default_nettype wire

/* logic/rx_frame_writer.sv */
// stores MAC receive words in the frame RAM and queues one descriptor per received frame
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer #(
    parameter int frame_addr_w = 11
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire frame_pkg::mac_rx_t                mac_rx,
    output logic                                   ram_we,
    output logic [frame_addr_w-1:0]                ram_waddr,
    output logic [frame_pkg::frame_data_w-1:0]     ram_wdata,
    output logic                                   desc_wr,
    output frame_pkg::frame_desc_t                 desc
);

    logic [frame_addr_w-1:0] waddr;
    logic [frame_addr_w-1:0] start_addr;
    logic                    frame_open;
    logic                    beat_sop;
    logic                    beat_eop;

    assign beat_sop = mac_rx.valid && mac_rx.sop;
    assign beat_eop = mac_rx.valid && mac_rx.eop;

    // every valid word goes straight into the RAM
    assign ram_we    = mac_rx.valid;
    assign ram_waddr = waddr;
    assign ram_wdata = mac_rx.data;

    // write pointer wraps around the frame RAM
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            waddr      <= '0;
            start_addr <= '0;
            frame_open <= 1'b0;
        end
        else
        begin
            if (mac_rx.valid)
                waddr <= waddr + 1'b1;
            if (beat_sop)
                start_addr <= waddr;
            if (beat_eop)
                frame_open <= 1'b0;
            else if (beat_sop)
                frame_open <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            desc_wr <= 1'b0;
        else
            desc_wr <= beat_eop;
    end

    // length, class and filter index are only valid with eop
    always_ff @(posedge clk)
    begin
        if (beat_eop)
        begin
            desc.start_addr   <= beat_sop ? waddr : start_addr;
            desc.len          <= mac_rx.frmlen;
            desc.pkt_class    <= mac_rx.pkt_type;
            desc.filter_index <= mac_rx.udp_filter_index;
        end
    end

    a_no_sop_in_frame: assert property (@(posedge clk) disable iff (rst)
        beat_sop |-> !frame_open)
        else $error("sop seen while a frame is still open");

endmodule

`default_nettype wire

/* logic/frame_ram.sv */
// simple dual-port frame RAM, one write port and one registered read port on the same clock
`timescale 1ns/1ps
`default_nettype none

module frame_ram #(
    parameter int addr_w = 11,
    parameter int data_w = 32
) (
    input  wire logic              clk,
    input  wire logic              we,
    input  wire logic [addr_w-1:0] waddr,
    input  wire logic [data_w-1:0] wdata,
    input  wire logic [addr_w-1:0] raddr,
    output logic [data_w-1:0]      rdata
);

    logic [data_w-1:0] mem [0:(1 << addr_w)-1];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
    end

    // read data follows the address by one cycle
    always_ff @(posedge clk)
    begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

/* logic/desc_fifo.sv */
// synchronous FIFO of frame descriptors between the writer and the reader, registered read
`timescale 1ns/1ps
`default_nettype none

module desc_fifo #(
    parameter int depth_w = 4
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   wr,
    input  wire frame_pkg::frame_desc_t wdata,
    input  wire logic                   rd,
    output frame_pkg::frame_desc_t      rdata,
    output logic                        empty,
    output logic                        full
);

    frame_pkg::frame_desc_t mem [0:(1 << depth_w)-1];

    // extra top bit tells full from empty
    logic [depth_w:0] wr_ptr;
    logic [depth_w:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[depth_w] != rd_ptr[depth_w]) &&
                   (wr_ptr[depth_w-1:0] == rd_ptr[depth_w-1:0]);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (wr && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr && !full)
            mem[wr_ptr[depth_w-1:0]] <= wdata;
        if (rd && !empty)
            rdata <= mem[rd_ptr[depth_w-1:0]];
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr |-> !full)
        else $error("descriptor written into a full FIFO");

    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        rd |-> !empty)
        else $error("descriptor read from an empty FIFO");

endmodule

`default_nettype wire

/* logic/udp_frame_reader.sv */
// pops frame descriptors, drops non-UDP-match frames and issues the payload reads of the rest
`timescale 1ns/1ps
`default_nettype none

module udp_frame_reader #(
    parameter int frame_addr_w = 11
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   fifo_empty,
    input  wire frame_pkg::frame_desc_t fifo_rdata,
    output logic                        fifo_rd,
    output logic [frame_addr_w-1:0]     ram_raddr,
    output udp_out_pkg::rd_beat_t       beat,
    output frame_pkg::frame_desc_t      cur_desc
);

    // frame word that holds the first payload byte
    localparam int hdr_words = udp_out_pkg::udp_hdr_bytes / 4;

    typedef enum logic [2:0] {
        st_idle,
        st_pop,
        st_wait,
        st_load,
        st_copy,
        st_done
    } state_e;

    state_e                state;
    state_e                state_nxt;
    frame_pkg::frame_len_t pay_len;
    frame_pkg::frame_len_t pay_round;
    logic [9:0]            last_idx;
    logic [9:0]            rd_cnt;

    // payload length rounded up to whole words
    assign pay_len   = cur_desc.len - frame_pkg::frame_len_t'(udp_out_pkg::udp_hdr_bytes);
    assign pay_round = pay_len + 12'd3;

    always_comb
    begin
        state_nxt = state;
        case (state)
            st_idle:
            begin
                if (!fifo_empty)
                    state_nxt = st_pop;
            end
            st_pop:  state_nxt = st_wait;
            st_wait: state_nxt = st_load;
            st_load:
            begin
                if (cur_desc.pkt_class == frame_pkg::udp_match)
                    state_nxt = st_copy;
                else
                    state_nxt = st_idle;
            end
            st_copy:
            begin
                if (rd_cnt == last_idx)
                    state_nxt = st_done;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    assign fifo_rd = (state == st_pop);

    // FIFO data shows up the cycle after the pop
    always_ff @(posedge clk)
    begin
        if (state == st_wait)
            cur_desc <= fifo_rdata;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ram_raddr <= '0;
            rd_cnt    <= '0;
            last_idx  <= '0;
        end
        else if (state == st_load)
        begin
            ram_raddr <= cur_desc.start_addr + frame_addr_w'(hdr_words);
            rd_cnt    <= '0;
            last_idx  <= pay_round[11:2];
        end
        else if (state == st_copy)
        begin
            ram_raddr <= ram_raddr + 1'b1;
            rd_cnt    <= rd_cnt + 1'b1;
        end
    end

    // one cycle late so it meets the RAM read data
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            beat <= '0;
        else
        begin
            beat.valid <= (state == st_copy);
            beat.first <= (state == st_copy) && (rd_cnt == '0);
            beat.last  <= (state == st_copy) && (rd_cnt == last_idx);
        end
    end

endmodule

`default_nettype wire

/* logic/udp_payload_aligner.sv */
// shifts frame words by 16 bits into UDP payload words and writes them with their descriptor
`timescale 1ns/1ps
`default_nettype none

module udp_payload_aligner #(
    parameter int udp_addr_w = 10
) (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire udp_out_pkg::rd_beat_t             beat,
    input  wire logic [frame_pkg::frame_data_w-1:0] ram_rdata,
    input  wire frame_pkg::frame_desc_t            cur_desc,
    output udp_out_pkg::udp_wr_t                   udp_wr,
    output udp_out_pkg::udp_desc_t                 udp_desc
);

    localparam int half_w = frame_pkg::frame_data_w / 2;

    logic [half_w-1:0]                 low_half;
    logic [frame_pkg::frame_data_w-1:0] wdata;
    logic                              wren;
    logic                              wr_last;
    logic [udp_addr_w-1:0]             waddr;
    logic [udp_addr_w-1:0]             start_addr;
    logic                              desc_valid;
    logic [15:0]                       dst_port;
    logic [11:0]                       pay_len;
    logic [udp_addr_w-1:0]             desc_start;

    // the first beat only primes the low half
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wren       <= 1'b0;
            wr_last    <= 1'b0;
            desc_valid <= 1'b0;
        end
        else
        begin
            wren       <= beat.valid && !beat.first;
            wr_last    <= beat.valid && beat.last;
            desc_valid <= wren && wr_last;
        end
    end

    always_ff @(posedge clk)
    begin
        if (beat.valid)
            low_half <= ram_rdata[half_w-1:0];
        if (beat.valid && !beat.first)
            wdata <= {low_half, ram_rdata[frame_pkg::frame_data_w-1:half_w]};
        if (beat.valid && beat.first)
            start_addr <= waddr;
    end

    // output address runs on across frames and wraps
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            waddr <= '0;
        else if (wren)
            waddr <= waddr + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (wren && wr_last)
        begin
            dst_port   <= cur_desc.filter_index;
            pay_len    <= cur_desc.len - frame_pkg::frame_len_t'(udp_out_pkg::udp_hdr_bytes);
            desc_start <= start_addr;
        end
    end

    assign udp_wr   = '{wren: wren, waddr: waddr, wdata: wdata};
    assign udp_desc = '{valid: desc_valid, dst_port: dst_port, pay_len: pay_len,
                        start_addr: desc_start};

    // no write of the previous frame overlaps a first beat and reads come back to back
    a_first_beat_no_write: assert property (@(posedge clk) disable iff (rst)
        beat.valid && beat.first |-> !wren ##2 wren)
        else $error("write pattern broken around a first beat");

endmodule

`default_nettype wire

/* logic/gbe_rx_frmbuf.sv */
// top level of the receive frame buffer, chains writer, RAM, FIFO, reader and aligner
`timescale 1ns/1ps
`default_nettype none

module gbe_rx_frmbuf #(
    parameter int frame_addr_w = 11,
    parameter int desc_depth_w = 4,
    parameter int udp_addr_w   = 10
) (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire frame_pkg::mac_rx_t mac_rx,
    output udp_out_pkg::udp_wr_t    udp_wr,
    output udp_out_pkg::udp_desc_t  udp_desc
);

    logic                               ram_we;
    logic [frame_addr_w-1:0]            ram_waddr;
    logic [frame_addr_w-1:0]            ram_raddr;
    logic [frame_pkg::frame_data_w-1:0] ram_wdata;
    logic [frame_pkg::frame_data_w-1:0] ram_rdata;
    logic                               desc_wr;
    logic                               fifo_rd;
    logic                               fifo_empty;
    frame_pkg::frame_desc_t             wr_desc;
    frame_pkg::frame_desc_t             fifo_rdata;
    frame_pkg::frame_desc_t             cur_desc;
    udp_out_pkg::rd_beat_t              rd_beat;

    rx_frame_writer #(
        .frame_addr_w (frame_addr_w)
    ) u_writer (
        .clk       (clk),
        .rst       (rst),
        .mac_rx    (mac_rx),
        .ram_we    (ram_we),
        .ram_waddr (ram_waddr),
        .ram_wdata (ram_wdata),
        .desc_wr   (desc_wr),
        .desc      (wr_desc)
    );

    frame_ram #(
        .addr_w (frame_addr_w),
        .data_w (frame_pkg::frame_data_w)
    ) u_frame_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (ram_raddr),
        .rdata (ram_rdata)
    );

    desc_fifo #(
        .depth_w (desc_depth_w)
    ) u_desc_fifo (
        .clk   (clk),
        .rst   (rst),
        .wr    (desc_wr),
        .wdata (wr_desc),
        .rd    (fifo_rd),
        .rdata (fifo_rdata),
        .empty (fifo_empty),
        .full  ()
    );

    udp_frame_reader #(
        .frame_addr_w (frame_addr_w)
    ) u_reader (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .fifo_rdata (fifo_rdata),
        .fifo_rd    (fifo_rd),
        .ram_raddr  (ram_raddr),
        .beat       (rd_beat),
        .cur_desc   (cur_desc)
    );

    udp_payload_aligner #(
        .udp_addr_w (udp_addr_w)
    ) u_aligner (
        .clk       (clk),
        .rst       (rst),
        .beat      (rd_beat),
        .ram_rdata (ram_rdata),
        .cur_desc  (cur_desc),
        .udp_wr    (udp_wr),
        .udp_desc  (udp_desc)
    );

endmodule

`default_nettype wire

/* dv/gbe_rx_frmbuf_tb.sv */
// testbench for the receive frame buffer that sends random MAC frames and checks the UDP port
`timescale 1ns/1ps
`default_nettype none

module gbe_rx_frmbuf_tb;

    localparam int frame_addr_w = 11;
    localparam int desc_depth_w = 4;
    localparam int udp_addr_w   = 10;
    localparam int hdr_bytes    = udp_out_pkg::udp_hdr_bytes;

    logic                   clk;
    logic                   rst;
    frame_pkg::mac_rx_t     mac_rx;
    udp_out_pkg::udp_wr_t   udp_wr;
    udp_out_pkg::udp_desc_t udp_desc;

    // bytes of the frame currently being sent
    logic [7:0] frame_bytes [0:511];

    udp_out_pkg::udp_wr_t   exp_words [$];
    logic [31:0]            exp_masks [$];
    udp_out_pkg::udp_desc_t exp_descs [$];

    logic [31:0]           lfsr;
    logic [udp_addr_w-1:0] model_addr;
    logic [udp_addr_w-1:0] last_waddr;
    logic                  saw_wrap;
    int                    total_words;
    int                    budget;
    int                    cycle_cnt;
    int                    err_count;
    int                    chk_count;
    int                    test_err_base;
    int                    test_chk_base;

    gbe_rx_frmbuf #(
        .frame_addr_w (frame_addr_w),
        .desc_depth_w (desc_depth_w),
        .udp_addr_w   (udp_addr_w)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .mac_rx   (mac_rx),
        .udp_wr   (udp_wr),
        .udp_desc (udp_desc)
    );

    always #20 clk = ~clk;

    // galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic random_len(output int len);
        logic [31:0] r;
        draw_bits(9, r);
        len = 60 + (int'(r[8:0]) % 341);
    endtask

    // payload word k with the first byte on top
    function automatic logic [31:0] ref_word(input int k);
        int b;
        b = hdr_bytes + 4 * k;
        return {frame_bytes[b], frame_bytes[b + 1], frame_bytes[b + 2], frame_bytes[b + 3]};
    endfunction

    // only bytes inside the frame length count
    function automatic logic [31:0] byte_mask(input int len, input int k);
        logic [31:0] m;
        int          b;
        int          i;
        m = '0;
        b = hdr_bytes + 4 * k;
        for (i = 0; i < 4; i++)
        begin
            if (b + i < len)
                m[31 - 8 * i -: 8] = 8'hff;
        end
        return m;
    endfunction

    function automatic udp_out_pkg::udp_desc_t ref_desc(input int len, input logic [15:0] filt,
                                                        input logic [udp_addr_w-1:0] start);
        udp_out_pkg::udp_desc_t d;
        d.valid      = 1'b1;
        d.dst_port   = filt;
        d.pay_len    = 12'(len - hdr_bytes);
        d.start_addr = start;
        return d;
    endfunction

    task automatic queue_expected(input int len, input logic [15:0] filt);
        udp_out_pkg::udp_wr_t w;
        int                   n;
        int                   k;
        n = (len - hdr_bytes + 3) / 4;
        exp_descs.push_back(ref_desc(len, filt, model_addr));
        for (k = 0; k < n; k++)
        begin
            w.wren  = 1'b1;
            w.waddr = model_addr + udp_addr_w'(k);
            w.wdata = ref_word(k);
            exp_words.push_back(w);
            exp_masks.push_back(byte_mask(len, k));
        end
        model_addr  = model_addr + udp_addr_w'(n);
        total_words = total_words + n;
    endtask

    task automatic send_frame(input int len, input frame_pkg::pkt_class_e cls,
                              input logic [15:0] filt, input int gap);
        frame_pkg::mac_rx_t beat;
        logic [31:0]        r;
        int                 nwords;
        int                 i;
        int                 w;
        nwords = (len + 3) / 4;
        for (i = 0; i < nwords * 4; i++)
        begin
            draw_bits(8, r);
            frame_bytes[i] = r[7:0];
        end
        if (cls == frame_pkg::udp_match)
            queue_expected(len, filt);
        budget = budget + nwords + gap;
        for (w = 0; w < nwords; w++)
        begin
            beat.sop              = (w == 0);
            beat.eop              = (w == nwords - 1);
            beat.valid            = 1'b1;
            beat.data             = {frame_bytes[4 * w], frame_bytes[4 * w + 1],
                                     frame_bytes[4 * w + 2], frame_bytes[4 * w + 3]};
            beat.frmlen           = 12'(len);
            beat.pkt_type         = cls;
            beat.udp_filter_index = filt;
            @(posedge clk);
            mac_rx <= beat;
        end
        for (i = 0; i < gap; i++)
        begin
            @(posedge clk);
            mac_rx <= '0;
        end
    endtask

    task automatic check_word(input udp_out_pkg::udp_wr_t got, input udp_out_pkg::udp_wr_t exp,
                              input logic [31:0] mask);
        chk_count++;
        if (got.waddr !== exp.waddr || ((got.wdata ^ exp.wdata) & mask) !== 32'h0)
        begin
            err_count++;
            $display("[ERROR] %0t ns: payload word %08h at %0d, expected %08h at %0d (mask %08h)",
                     $time, got.wdata, got.waddr, exp.wdata, exp.waddr, mask);
        end
    endtask

    task automatic check_desc(input udp_out_pkg::udp_desc_t got,
                              input udp_out_pkg::udp_desc_t exp);
        chk_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("[ERROR] %0t ns: descriptor port %04h len %0d start %0d, expected %04h %0d %0d",
                     $time, got.dst_port, got.pay_len, got.start_addr,
                     exp.dst_port, exp.pay_len, exp.start_addr);
        end
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk)
    begin
        if (!rst && udp_wr.wren === 1'b1)
        begin
            if (exp_words.size() == 0)
            begin
                err_count++;
                $display("unexpected payload write at %0t ns to address %0d, no frame pending",
                         $time, udp_wr.waddr);
            end
            else
                check_word(udp_wr, exp_words.pop_front(), exp_masks.pop_front());
            if (last_waddr == '1 && udp_wr.waddr == '0)
                saw_wrap = 1'b1;
            last_waddr = udp_wr.waddr;
        end
        if (!rst && udp_desc.valid === 1'b1)
        begin
            if (exp_descs.size() == 0)
            begin
                err_count++;
                $display("unexpected output descriptor at %0t ns, no frame pending", $time);
            end
            else
                check_desc(udp_desc, exp_descs.pop_front());
        end
    end

    task automatic start_test();
        test_err_base = err_count;
        test_chk_base = chk_count;
    endtask

    // wait until every queued word and descriptor came out and then a quiet window
    task automatic drain_outputs();
        while (exp_words.size() != 0 || exp_descs.size() != 0)
            @(posedge clk);
        budget = budget + 20;
        repeat (20) @(posedge clk);
    endtask

    task automatic report_test(input string name);
        int errs;
        int chks;
        errs = err_count - test_err_base;
        chks = chk_count - test_chk_base;
        if (errs == 0)
            $display("test %s: ok, %0d checks", name, chks);
        else
            $display("test %s: %0d errors in %0d checks", name, errs, chks);
    endtask

    // limit grows with every frame and gap that is sent
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt <= 2 * budget + 200)
        begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, expected output never arrived", cycle_cnt);
        $display("CHECKS FAILED");
        $finish;
    end

    initial
    begin
        int                    i;
        int                    len;
        int                    gap;
        logic [31:0]           r;
        logic [15:0]           filt;
        frame_pkg::pkt_class_e cls;

        clk         = 1'b0;
        rst         = 1'b1;
        mac_rx      = '0;
        lfsr        = 32'h59c3;
        model_addr  = '0;
        last_waddr  = '0;
        saw_wrap    = 1'b0;
        total_words = 0;
        err_count   = 0;
        chk_count   = 0;
        budget      = 14;
        for (i = 0; i < 512; i++)
            frame_bytes[i] = 8'h00;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        start_test();
        for (i = 0; i < 10; i++)
        begin
            @(negedge clk);
            chk_count++;
            if (udp_wr.wren !== 1'b0 || udp_desc.valid !== 1'b0)
            begin
                err_count++;
                $display("[ERROR] %0t ns: write enable or descriptor valid not low after reset",
                         $time);
            end
        end
        report_test("reset_state");

        // payload lengths 18 and 20 cover both word endings
        start_test();
        send_frame(60, frame_pkg::udp_match, 16'h1234, 20);
        send_frame(62, frame_pkg::udp_match, 16'h0035, 20);
        for (i = 0; i < 4; i++)
        begin
            random_len(len);
            draw_bits(16, r);
            send_frame(len, frame_pkg::udp_match, r[15:0], (len + 3) / 4 + 4);
        end
        drain_outputs();
        report_test("payload_realign");

        start_test();
        random_len(len);
        send_frame(len, frame_pkg::other, 16'h0001, (len + 3) / 4);
        random_len(len);
        send_frame(len, frame_pkg::ip_match, 16'h0002, (len + 3) / 4);
        random_len(len);
        send_frame(len, frame_pkg::checksum_err, 16'h0003, (len + 3) / 4);
        random_len(len);
        send_frame(len, frame_pkg::udp_match, 16'h0e11, (len + 3) / 4);
        drain_outputs();
        report_test("filtering");

        // short frames one idle cycle apart
        start_test();
        for (i = 0; i < 6; i++)
        begin
            draw_bits(4, r);
            len = 60 + int'(r[3:0]);
            draw_bits(16, r);
            send_frame(len, frame_pkg::udp_match, r[15:0], 1);
        end
        drain_outputs();
        report_test("back_to_back");

        start_test();
        while (total_words < 1100)
        begin
            random_len(len);
            draw_bits(3, r);
            case (r[2:0])
                3'd5:    cls = frame_pkg::other;
                3'd6:    cls = frame_pkg::ip_match;
                3'd7:    cls = frame_pkg::checksum_err;
                default: cls = frame_pkg::udp_match;
            endcase
            draw_bits(16, r);
            filt = r[15:0];
            draw_bits(4, r);
            gap = (len + 3) / 4 + int'(r[3:0]);
            send_frame(len, cls, filt, gap);
        end
        drain_outputs();
        chk_count++;
        if (!saw_wrap)
        begin
            err_count++;
            $display("output address never wrapped from 1023 to 0 during the long run");
        end
        report_test("long_run_wrap");

        $display("total: %0d checks, %0d errors", chk_count, err_count);
        if (err_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
logic/frame_pkg.sv
logic/udp_out_pkg.sv
logic/rx_frame_writer.sv
logic/frame_ram.sv
logic/desc_fifo.sv
logic/udp_frame_reader.sv
logic/udp_payload_aligner.sv
logic/gbe_rx_frmbuf.sv
dv/gbe_rx_frmbuf_tb.sv
